// ==== verilog/bankmem_params.svh ====
`ifndef BANKMEM_PARAMS_SVH
`define BANKMEM_PARAMS_SVH

// Data path and bank geometry.
`define BM_DATA_W 32
`define BM_NUM_BANK 8
`define BM_BANK_W 3
`define BM_ROW_W 6

// Read latency of every memory, in cycles.
`define BM_READ_DELAY 2

// Queue depths and credit counts on both host interfaces.
`define BM_IN_CREDITS 4
`define BM_OUT_DEPTH 8
`define BM_OUT_CREDITS 4

// Metadata word holds valid, bank and parity.
`define BM_META_W (`BM_BANK_W + 2)

`endif

// ==== verilog/bankmem_pkg.sv ====
`default_nettype none

`include "bankmem_params.svh"

package bankmem_pkg;

  typedef enum logic [1:0] {
    OP_READ   = 2'd0,
    OP_WRITE  = 2'd1,
    OP_LOOKUP = 2'd2
  } req_op_e;

  typedef struct packed {
    req_op_e               op;
    logic [`BM_BANK_W-1:0] bank;
    logic [`BM_ROW_W-1:0]  row;
    logic [`BM_DATA_W-1:0] data;
  } mem_req_t;

  // Parity is the XOR of all data bits of the stored word.
  typedef struct packed {
    logic                  valid;
    logic [`BM_BANK_W-1:0] bank;
    logic                  parity;
  } meta_entry_t;

  typedef struct packed {
    logic [`BM_DATA_W-`BM_META_W-1:0] pad;
    meta_entry_t                      entry;
  } rsp_meta_view_t;

  // A read returns a data word, a lookup returns a metadata entry.
  typedef union packed {
    logic [`BM_DATA_W-1:0] data;
    rsp_meta_view_t        meta;
  } rsp_payload_u;

  // Kind is OP_READ or OP_LOOKUP.
  typedef struct packed {
    req_op_e      kind;
    logic         hit;
    logic         parity_ok;
    rsp_payload_u payload;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/bank_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bankmem_params.svh"

module bank_sram #(
  parameter int WIDTH   = `BM_DATA_W,
  parameter int DEPTH_W = `BM_ROW_W
) (
  input  wire               clk,
  input  wire               read,
  input  wire [DEPTH_W-1:0] rd_addr,
  output logic [WIDTH-1:0]  dout,
  input  wire               write,
  input  wire [DEPTH_W-1:0] wr_addr,
  input  wire [WIDTH-1:0]   din
);

  localparam int ROWS  = 1 << DEPTH_W;
  localparam int DELAY = `BM_READ_DELAY;

  logic [WIDTH-1:0] mem [0:ROWS-1];
  logic [WIDTH-1:0] rd_pipe [0:DELAY-1];

  // A read and a write to the same row in one cycle return the old word.
  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_addr] <= din;
    end
    if (read) begin
      rd_pipe[0] <= mem[rd_addr];
    end
    for (int i = 1; i < DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[DELAY-1];

endmodule

`default_nettype wire

// ==== verilog/req_ingress.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bankmem_params.svh"

module req_ingress import bankmem_pkg::*; (
  input  wire           clk,
  input  wire           rst,
  input  wire           req_valid,
  input  wire mem_req_t req,
  output logic          req_credit,
  input  wire           rsp_room,
  output logic          issue_valid,
  output mem_req_t      issue
);

  localparam int DEPTH = `BM_IN_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mem_req_t          queue [0:DEPTH-1];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              deq;

  // Requests wait here until the egress has a free slot.
  assign deq         = (count != '0) && rsp_room;
  assign issue_valid = deq;
  assign issue       = queue[rd_ptr];

  always_ff @(posedge clk) begin
    if (req_valid) begin
      queue[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      req_credit <= deq;
      if (req_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({req_valid, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The host may only send while it holds a credit, so the queue never overflows.
  a_no_credit_overrun: assert property (
    @(posedge clk) disable iff (rst)
    req_valid |-> (count < CNT_W'(DEPTH))
  ) else $error("req_ingress: request received with the queue full");

endmodule

`default_nettype wire

// ==== verilog/bank_port_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bankmem_params.svh"

module bank_port_mux import bankmem_pkg::*; (
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire                                        issue_valid,
  input  wire mem_req_t                              issue,
  output logic [`BM_NUM_BANK-1:0]                    bank_read,
  output logic [`BM_NUM_BANK-1:0]                    bank_write,
  output logic [`BM_NUM_BANK-1:0][`BM_ROW_W-1:0]     bank_rd_row,
  output logic [`BM_NUM_BANK-1:0][`BM_ROW_W-1:0]     bank_wr_row,
  output logic [`BM_NUM_BANK-1:0][`BM_DATA_W-1:0]    bank_din,
  input  wire  [`BM_NUM_BANK-1:0][`BM_DATA_W-1:0]    bank_dout,
  output logic                                       meta_write,
  output logic [`BM_ROW_W-1:0]                       meta_wr_row,
  output meta_entry_t                                meta_din,
  output logic                                       meta_read1,
  output logic [`BM_ROW_W-1:0]                       meta_rd_row1,
  input  wire meta_entry_t                           meta_dout1,
  output logic                                       meta_read2,
  output logic [`BM_ROW_W-1:0]                       meta_rd_row2,
  input  wire meta_entry_t                           meta_dout2,
  output logic                                       issue_rsp,
  output logic                                       rsp_push,
  output mem_rsp_t                                   rsp_push_data
);

  localparam int NB    = `BM_NUM_BANK;
  localparam int ROWS  = 1 << `BM_ROW_W;
  localparam int DELAY = `BM_READ_DELAY;

  typedef struct packed {
    logic                  tok;
    req_op_e               kind;
    logic [`BM_BANK_W-1:0] bank;
    logic                  row_ok;
  } pipe_t;

  logic                  is_read;
  logic                  is_write;
  logic                  is_lookup;
  logic [ROWS-1:0]       row_valid;
  pipe_t                 pipe [0:DELAY-1];
  pipe_t                 tail;
  meta_entry_t           rd_meta;
  meta_entry_t           lk_meta;
  logic [`BM_DATA_W-1:0] rd_word;
  logic                  rd_hit;

  assign is_read   = issue_valid && (issue.op == OP_READ);
  assign is_write  = issue_valid && (issue.op == OP_WRITE);
  assign is_lookup = issue_valid && (issue.op == OP_LOOKUP);
  assign issue_rsp = is_read || is_lookup;

  // The row goes to every bank; only the addressed bank is enabled.
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      bank_read[b]   = is_read && (issue.bank == b);
      bank_write[b]  = is_write && (issue.bank == b);
      bank_rd_row[b] = issue.row;
      bank_wr_row[b] = issue.row;
      bank_din[b]    = issue.data;
    end
  end

  // Both metadata copies take the same write, each serves its own read port.
  assign meta_write   = is_write;
  assign meta_wr_row  = issue.row;
  assign meta_din     = '{valid: 1'b1, bank: issue.bank, parity: ^issue.data};
  assign meta_read1   = is_read;
  assign meta_rd_row1 = issue.row;
  assign meta_read2   = is_lookup;
  assign meta_rd_row2 = issue.row;

  always_ff @(posedge clk) begin
    if (rst) begin
      row_valid <= '0;
    end else if (is_write) begin
      row_valid[issue.row] <= 1'b1;
    end
  end

  // Tracks each read or lookup through the memory latency.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DELAY; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= '{tok: issue_rsp, kind: issue.op, bank: issue.bank,
                   row_ok: row_valid[issue.row]};
      for (int i = 1; i < DELAY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign tail     = pipe[DELAY-1];
  assign rsp_push = tail.tok;

  always_comb begin
    rd_meta = tail.row_ok ? meta_dout1 : '0;
    lk_meta = tail.row_ok ? meta_dout2 : '0;
    rd_word = bank_dout[tail.bank];
    rd_hit  = rd_meta.valid && (rd_meta.bank == tail.bank);
    rsp_push_data      = '0;
    rsp_push_data.kind = tail.kind;
    if (tail.kind == OP_LOOKUP) begin
      rsp_push_data.hit                = lk_meta.valid;
      rsp_push_data.parity_ok          = 1'b1;
      rsp_push_data.payload.meta.entry = lk_meta;
    end else begin
      rsp_push_data.hit          = rd_hit;
      rsp_push_data.parity_ok    = !rd_hit || ((^rd_word) == rd_meta.parity);
      rsp_push_data.payload.data = rd_word;
    end
  end

  a_one_bank_read: assert property (
    @(posedge clk) disable iff (rst) $onehot0(bank_read)
  ) else $error("bank_port_mux: more than one bank read enable active");

endmodule

`default_nettype wire

// ==== verilog/rsp_egress.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bankmem_params.svh"

module rsp_egress import bankmem_pkg::*; (
  input  wire           clk,
  input  wire           rst,
  input  wire           issue_rsp,
  input  wire           rsp_push,
  input  wire mem_rsp_t rsp_push_data,
  output logic          rsp_room,
  output logic          rsp_valid,
  output mem_rsp_t      rsp,
  input  wire           rsp_credit
);

  localparam int DEPTH   = `BM_OUT_DEPTH;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W   = $clog2(DEPTH + 1);
  localparam int CREDITS = `BM_OUT_CREDITS;
  localparam int CRD_W   = $clog2(CREDITS + 1);

  mem_rsp_t          queue [0:DEPTH-1];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CNT_W-1:0]  resv;
  logic [CNT_W:0]    used;
  logic [CRD_W-1:0]  credits;

  // Slots are reserved at issue so that an in-flight response always fits.
  assign used     = count + resv;
  assign rsp_room = used < (CNT_W + 1)'(DEPTH);

  assign rsp_valid = (count != '0) && (credits != '0);
  assign rsp       = queue[rd_ptr];

  always_ff @(posedge clk) begin
    if (rsp_push) begin
      queue[wr_ptr] <= rsp_push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      resv    <= '0;
      credits <= CRD_W'(CREDITS);
    end else begin
      if (rsp_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rsp_valid) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({rsp_push, rsp_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({issue_rsp, rsp_push})
        2'b10:   resv <= resv + 1'b1;
        2'b01:   resv <= resv - 1'b1;
        default: resv <= resv;
      endcase
      case ({rsp_credit, rsp_valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // The host can only return credits that it was given.
  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) credits <= CRD_W'(CREDITS)
  ) else $error("rsp_egress: output credit counter above its reset value");

endmodule

`default_nettype wire

// ==== verilog/bankmem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bankmem_params.svh"

module bankmem_top import bankmem_pkg::*; (
  input  wire           clk,
  input  wire           rst,
  input  wire           req_valid,
  input  wire mem_req_t req,
  output wire           req_credit,
  output wire           rsp_valid,
  output wire mem_rsp_t rsp,
  input  wire           rsp_credit
);

  wire                                     rsp_room;
  wire                                     issue_valid;
  wire mem_req_t                           issue;
  wire [`BM_NUM_BANK-1:0]                  bank_read;
  wire [`BM_NUM_BANK-1:0]                  bank_write;
  wire [`BM_NUM_BANK-1:0][`BM_ROW_W-1:0]   bank_rd_row;
  wire [`BM_NUM_BANK-1:0][`BM_ROW_W-1:0]   bank_wr_row;
  wire [`BM_NUM_BANK-1:0][`BM_DATA_W-1:0]  bank_din;
  wire [`BM_NUM_BANK-1:0][`BM_DATA_W-1:0]  bank_dout;
  wire                                     meta_write;
  wire [`BM_ROW_W-1:0]                     meta_wr_row;
  wire meta_entry_t                        meta_din;
  wire                                     meta_read1;
  wire [`BM_ROW_W-1:0]                     meta_rd_row1;
  wire meta_entry_t                        meta_dout1;
  wire                                     meta_read2;
  wire [`BM_ROW_W-1:0]                     meta_rd_row2;
  wire meta_entry_t                        meta_dout2;
  wire                                     issue_rsp;
  wire                                     rsp_push;
  wire mem_rsp_t                           rsp_push_data;

  req_ingress u_ingress (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .rsp_room    (rsp_room),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  bank_port_mux u_mux (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .bank_read     (bank_read),
    .bank_write    (bank_write),
    .bank_rd_row   (bank_rd_row),
    .bank_wr_row   (bank_wr_row),
    .bank_din      (bank_din),
    .bank_dout     (bank_dout),
    .meta_write    (meta_write),
    .meta_wr_row   (meta_wr_row),
    .meta_din      (meta_din),
    .meta_read1    (meta_read1),
    .meta_rd_row1  (meta_rd_row1),
    .meta_dout1    (meta_dout1),
    .meta_read2    (meta_read2),
    .meta_rd_row2  (meta_rd_row2),
    .meta_dout2    (meta_dout2),
    .issue_rsp     (issue_rsp),
    .rsp_push      (rsp_push),
    .rsp_push_data (rsp_push_data)
  );

  for (genvar b = 0; b < `BM_NUM_BANK; b++) begin : g_bank
    bank_sram #(.WIDTH(`BM_DATA_W), .DEPTH_W(`BM_ROW_W)) u_bank (
      .clk     (clk),
      .read    (bank_read[b]),
      .rd_addr (bank_rd_row[b]),
      .dout    (bank_dout[b]),
      .write   (bank_write[b]),
      .wr_addr (bank_wr_row[b]),
      .din     (bank_din[b])
    );
  end

  // Two metadata copies so that reads and lookups each own a read port.
  bank_sram #(.WIDTH(`BM_META_W), .DEPTH_W(`BM_ROW_W)) u_meta1 (
    .clk     (clk),
    .read    (meta_read1),
    .rd_addr (meta_rd_row1),
    .dout    (meta_dout1),
    .write   (meta_write),
    .wr_addr (meta_wr_row),
    .din     (meta_din)
  );

  bank_sram #(.WIDTH(`BM_META_W), .DEPTH_W(`BM_ROW_W)) u_meta2 (
    .clk     (clk),
    .read    (meta_read2),
    .rd_addr (meta_rd_row2),
    .dout    (meta_dout2),
    .write   (meta_write),
    .wr_addr (meta_wr_row),
    .din     (meta_din)
  );

  rsp_egress u_egress (
    .clk           (clk),
    .rst           (rst),
    .issue_rsp     (issue_rsp),
    .rsp_push      (rsp_push),
    .rsp_push_data (rsp_push_data),
    .rsp_room      (rsp_room),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .rsp_credit    (rsp_credit)
  );

endmodule

`default_nettype wire

// ==== verification/bankmem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bankmem_params.svh"

module bankmem_tb import bankmem_pkg::*; ();

  localparam int IN_CRD  = `BM_IN_CREDITS;
  localparam int OUT_CRD = `BM_OUT_CREDITS;
  localparam int NB      = `BM_NUM_BANK;
  localparam int ROWS    = 1 << `BM_ROW_W;
  localparam int TIMEOUT = 2000;

  logic          clk = 1'b0;
  logic          rst;
  logic          req_valid;
  mem_req_t      req;
  wire           req_credit;
  wire           rsp_valid;
  wire mem_rsp_t rsp;
  logic          rsp_credit;

  int     in_sent;
  int     in_returned;
  int     rsp_seen;
  int     crd_given;
  int     exp_total;
  int     check_errors;
  int     other_errors;
  integer seed;
  logic   hold_credits;
  logic   rand_stall;
  string  cur_test;

  // Shadow copies of the data banks and the metadata table.
  logic [`BM_DATA_W-1:0] shadow_data [0:NB-1][0:ROWS-1];
  meta_entry_t           shadow_meta [0:ROWS-1];
  mem_rsp_t              exp_q[$];
  string                 name_q[$];
  logic [`BM_BANK_W-1:0] wr_bank_q[$];
  logic [`BM_ROW_W-1:0]  wr_row_q[$];

  bankmem_top uut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  always #20 clk = ~clk;

  function automatic mem_rsp_t expect_read(input logic [`BM_BANK_W-1:0] bank,
                                           input logic [`BM_ROW_W-1:0] row);
    mem_rsp_t              e;
    meta_entry_t           m;
    logic [`BM_DATA_W-1:0] word;
    m    = shadow_meta[row];
    word = shadow_data[bank][row];
    e    = '0;
    e.kind         = OP_READ;
    e.hit          = m.valid && (m.bank == bank);
    // Stored words are never corrupted, so every read passes its parity check.
    e.parity_ok    = 1'b1;
    e.payload.data = word;
    return e;
  endfunction

  function automatic mem_rsp_t expect_lookup(input logic [`BM_ROW_W-1:0] row);
    mem_rsp_t e;
    e = '0;
    e.kind                 = OP_LOOKUP;
    e.hit                  = shadow_meta[row].valid;
    e.parity_ok            = 1'b1;
    e.payload.meta.entry   = shadow_meta[row];
    return e;
  endfunction

  // Waits for a host credit, updates the model and presents one request.
  task automatic send_req(input req_op_e op, input logic [`BM_BANK_W-1:0] bank,
                          input logic [`BM_ROW_W-1:0] row,
                          input logic [`BM_DATA_W-1:0] data);
    int waited;
    waited = 0;
    while ((in_sent - in_returned) >= IN_CRD && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if ((in_sent - in_returned) >= IN_CRD) begin
      other_errors++;
      $display("Timeout in %s: the DUT returned no request credit", cur_test);
    end else begin
      if (op == OP_WRITE) begin
        shadow_data[bank][row] = data;
        shadow_meta[row]       = '{valid: 1'b1, bank: bank, parity: ^data};
        wr_bank_q.push_back(bank);
        wr_row_q.push_back(row);
      end else begin
        exp_q.push_back((op == OP_READ) ? expect_read(bank, row) : expect_lookup(row));
        name_q.push_back(cur_test);
        exp_total++;
      end
      req_valid = 1'b1;
      req       = '{op: op, bank: bank, row: row, data: data};
      @(posedge clk);
      #1;
      req_valid = 1'b0;
    end
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || rsp_seen != crd_given || in_sent != in_returned)
           && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0 || rsp_seen != crd_given || in_sent != in_returned) begin
      other_errors++;
      $display("Timeout in %s: %0d responses still missing", cur_test, exp_q.size());
    end
  endtask

  // Host side of the response credits: returns them at once or after a stall.
  initial begin : credit_return
    int stall;
    stall      = 0;
    rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rsp_credit = 1'b0;
      if (!rst && !hold_credits) begin
        if (stall > 0) begin
          stall--;
        end else if (rsp_seen - crd_given > 0) begin
          rsp_credit = 1'b1;
          if (rand_stall) begin
            stall = $unsigned($random(seed)) % 4;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      in_sent     <= 0;
      in_returned <= 0;
      rsp_seen    <= 0;
      crd_given   <= 0;
    end else begin
      if (req_valid) in_sent <= in_sent + 1;
      if (req_credit) in_returned <= in_returned + 1;
      if (rsp_credit) crd_given <= crd_given + 1;
      if (rsp_valid) begin
        rsp_seen <= rsp_seen + 1;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Response received in %s with no request pending", cur_test);
        end else begin
          assert (rsp === exp_q[0]) else begin
            check_errors++;
            $display("CHECK FAILED %s expected %h actual %h", name_q[0], exp_q[0], rsp);
          end
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
        end
      end
    end
  end

  a_idle_after_reset: assert property (
    @(posedge clk) disable iff (rst) (in_sent == 0) |-> (!rsp_valid && !req_credit)
  ) else begin
    check_errors++;
    $display("CHECK FAILED idle_after_reset expected 00 actual %b%b", rsp_valid, req_credit);
  end

  a_rsp_within_credit: assert property (
    @(posedge clk) disable iff (rst) rsp_valid |-> (rsp_seen - crd_given) < OUT_CRD
  ) else begin
    check_errors++;
    $display("CHECK FAILED rsp_within_credit expected below %0d actual %0d",
             OUT_CRD, rsp_seen - crd_given);
  end

  // A spare request credit would let the host overrun the ingress queue.
  a_credit_after_request: assert property (
    @(posedge clk) disable iff (rst) req_credit |-> (in_sent > in_returned)
  ) else begin
    check_errors++;
    $display("Request credit returned with no request outstanding");
  end

  initial begin : main
    int                    i;
    int                    idx;
    int                    waited;
    int                    quiet;
    logic [`BM_ROW_W-1:0]  r;
    logic [`BM_DATA_W-1:0] d1;
    logic [`BM_DATA_W-1:0] d2;
    seed         = 88;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    hold_credits = 1'b0;
    rand_stall   = 1'b0;
    exp_total    = 0;
    check_errors = 0;
    other_errors = 0;
    cur_test     = "reset";
    for (int b = 0; b < NB; b++) begin
      for (int j = 0; j < ROWS; j++) begin
        shadow_data[b][j] = '0;
      end
    end
    for (int j = 0; j < ROWS; j++) begin
      shadow_meta[j] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    cur_test = "reset_idle";
    repeat (10) @(posedge clk);
    #1;
    for (i = 0; i < 4; i++) begin
      send_req(OP_LOOKUP, '0, `BM_ROW_W'($random(seed)), '0);
    end
    drain_all();

    cur_test   = "write_read";
    rand_stall = 1'b1;
    for (i = 0; i < 16; i++) begin
      send_req(OP_WRITE, `BM_BANK_W'($random(seed)), `BM_ROW_W'($random(seed)),
               $random(seed));
    end
    for (i = 0; i < 16; i++) begin
      send_req(OP_READ, wr_bank_q[i], wr_row_q[i], '0);
    end
    drain_all();

    // Two banks share a row, so the metadata follows only the later write.
    cur_test = "bank_mismatch";
    r  = `BM_ROW_W'($random(seed));
    d1 = $random(seed);
    d2 = $random(seed);
    send_req(OP_WRITE, 3'd1, r, d1);
    send_req(OP_WRITE, 3'd5, r, d2);
    send_req(OP_READ, 3'd1, r, '0);
    send_req(OP_READ, 3'd5, r, '0);
    send_req(OP_LOOKUP, '0, r, '0);
    drain_all();

    cur_test     = "backpressure";
    rand_stall   = 1'b0;
    hold_credits = 1'b1;
    fork
      begin
        for (i = 0; i < 24; i++) begin
          idx = $unsigned($random(seed)) % wr_bank_q.size();
          if (i % 3 == 2) begin
            send_req(OP_LOOKUP, '0, wr_row_q[idx], '0);
          end else begin
            send_req(OP_READ, wr_bank_q[idx], wr_row_q[idx], '0);
          end
        end
      end
      begin
        waited = 0;
        quiet  = 0;
        while (quiet < 20 && waited < TIMEOUT) begin
          @(posedge clk);
          #1;
          quiet = req_credit ? 0 : quiet + 1;
          waited++;
        end
        if (quiet < 20) begin
          other_errors++;
          $display("Timeout in %s: request credits kept flowing", cur_test);
        end
        if (in_sent - in_returned != IN_CRD) begin
          check_errors++;
          $display("CHECK FAILED %s expected %0d actual %0d", cur_test,
                   IN_CRD, in_sent - in_returned);
        end
        if (rsp_seen - crd_given != OUT_CRD) begin
          check_errors++;
          $display("CHECK FAILED %s expected %0d actual %0d", cur_test,
                   OUT_CRD, rsp_seen - crd_given);
        end
        hold_credits = 1'b0;
      end
    join
    rand_stall = 1'b1;
    drain_all();

    cur_test = "credit_balance";
    if (in_returned != in_sent) begin
      check_errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", cur_test, in_sent, in_returned);
    end
    if (rsp_seen != exp_total) begin
      check_errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", cur_test, exp_total, rsp_seen);
    end

    $display("Errors: %0d check failures, %0d other failures", check_errors, other_errors);
    if (check_errors + other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/bankmem_pkg.sv
verilog/bank_sram.sv
verilog/req_ingress.sv
verilog/bank_port_mux.sv
verilog/rsp_egress.sv
verilog/bankmem_top.sv
verification/bankmem_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := bankmem_tb
RTL_TOP    := bankmem_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
